// ==== Bender.yml ====
package:
  name: posit_adder

sources:
  - files:
      - source/posit_format_pkg.sv
      - source/posit_value_pkg.sv
      - source/posit_decode.sv
      - source/posit_add_core.sv
      - source/posit_round_pack.sv
      - source/posit_adder.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_posit_adder.sv

// ==== compile.f ====
+incdir+test
source/posit_format_pkg.sv
source/posit_value_pkg.sv
source/posit_decode.sv
source/posit_add_core.sv
source/posit_round_pack.sv
source/posit_adder.sv
test/tb_posit_adder.sv

// ==== source/posit_add_core.sv ====
/* Three register stages: compare/swap, sum, normalize
   core_valid follows start by four edges, counting the decoder register
   Scales below the 9-bit range clamp to the most negative scale */
`timescale 1ns/100ps

module posit_add_core
    import posit_format_pkg::*, posit_value_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  posit_value       a_value,
    input  logic [NBITS-2:0] a_magnitude,
    input  posit_value       b_value,
    input  logic [NBITS-2:0] b_magnitude,
    output posit_sum         sum_info,
    output logic [ABITS:0]   norm_fraction,   // Hidden bit at the top
    output logic             truncated,
    output logic             rounded_zero,
    output logic             core_valid
);

    localparam int GBITS = ABITS - FBITS - 1;   // Guard bits below the fraction

    logic start_q;    // Lines up with the decoder register
    logic s1_valid;
    logic s2_valid;

    logic       a_is_larger;
    posit_value s1_hi;
    posit_value s1_lo;
    logic       s1_add;

    logic [SBITS:0]     scale_diff;
    logic [ABITS-1:0]   lo_significand;
    logic [2*ABITS-1:0] lo_aligned;
    logic [ABITS:0]     hi_significand;
    logic [ABITS:0]     lo_upper;
    logic               align_lost;
    logic [ABITS:0]     sum_raw;
    posit_sum           s2_info;
    logic [ABITS:0]     s2_sum;
    logic               s2_truncated;

    logic [LZBITS-1:0] lead_zeros;
    logic [SBITS:0]    lead_zeros_ext;
    logic [SBITS:0]    scale_wide;
    logic [SBITS-1:0]  scale_clamped;
    posit_sum          norm_info;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start_q    <= 1'b0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            core_valid <= 1'b0;
        end
        else
        begin
            start_q    <= start;
            s1_valid   <= start_q;
            s2_valid   <= s1_valid;
            core_valid <= s2_valid;
        end
    end

    // Larger magnitude goes to the high side
    assign a_is_larger = (a_magnitude >= b_magnitude);

    always_ff @(posedge clk)
    begin
        s1_hi  <= a_is_larger ? a_value : b_value;
        s1_lo  <= a_is_larger ? b_value : a_value;
        s1_add <= (a_value.sign == b_value.sign);   // Unequal signs subtract
    end

    // Never negative, the high side has the larger scale
    assign scale_diff = {s1_hi.scale[SBITS-1], s1_hi.scale}
                      - {s1_lo.scale[SBITS-1], s1_lo.scale};

    assign lo_significand = {~s1_lo.zero, s1_lo.fraction, {GBITS{1'b0}}};
    assign lo_aligned     = {lo_significand, {ABITS{1'b0}}} >> scale_diff;

    // Far shifts push every bit past the double-width field
    assign align_lost = (|lo_aligned[ABITS-1:0])
                      | (~s1_lo.zero & (scale_diff >= ABITS));

    assign hi_significand = {1'b0, ~s1_hi.zero, s1_hi.fraction, {GBITS{1'b0}}};
    assign lo_upper       = {1'b0, lo_aligned[2*ABITS-1:ABITS]};

    // Lost bits borrow one unit on subtract so the sticky rounds the right way
    assign sum_raw = s1_add ? hi_significand + lo_upper
                            : hi_significand - lo_upper - {{ABITS{1'b0}}, align_lost};

    always_ff @(posedge clk)
    begin
        s2_info.sign  <= s1_hi.sign;
        s2_info.zero  <= s1_hi.zero & s1_lo.zero;
        s2_info.nar   <= s1_hi.nar | s1_lo.nar;
        s2_info.scale <= s1_hi.scale;
        s2_sum        <= sum_raw;
        s2_truncated  <= align_lost;
    end

    always_comb
    begin
        lead_zeros = LZBITS'(ABITS + 1);   // Full cancellation
        for (int i = 0; i <= ABITS; i++)
        begin
            if (s2_sum[i])
            begin
                lead_zeros = LZBITS'(ABITS - i);
            end
        end
    end

    // Carry adds one, cancellation subtracts the extra leading zeros
    assign lead_zeros_ext = {{(SBITS + 1 - LZBITS){1'b0}}, lead_zeros};
    assign scale_wide     = {s2_info.scale[SBITS-1], s2_info.scale} - lead_zeros_ext
                          + (SBITS + 1)'(1);
    assign scale_clamped  = (scale_wide[SBITS] != scale_wide[SBITS-1])
                          ? {1'b1, {(SBITS - 1){1'b0}}}
                          : scale_wide[SBITS-1:0];

    always_comb
    begin
        norm_info       = s2_info;
        norm_info.scale = scale_clamped;
    end

    always_ff @(posedge clk)
    begin
        sum_info      <= norm_info;
        norm_fraction <= s2_sum << lead_zeros;
        truncated     <= s2_truncated;
        rounded_zero  <= (s2_sum == '0);
    end

endmodule

// ==== source/posit_adder.sv ====
/* Pipelined posit<32,3> adder, one operation per cycle, no back-pressure
   done follows start by LATENCY edges, results leave in issue order */
`timescale 1ns/100ps

module posit_adder
    import posit_format_pkg::*, posit_value_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [NBITS-1:0] in1,
    input  logic [NBITS-1:0] in2,
    output logic [NBITS-1:0] result,
    output logic             nar,
    output logic             zero,
    output logic             done
);

    posit_value       a_value;
    posit_value       b_value;
    logic [NBITS-2:0] a_magnitude;
    logic [NBITS-2:0] b_magnitude;

    posit_sum         sum_info;
    logic [ABITS:0]   norm_fraction;
    logic             truncated;
    logic             rounded_zero;
    logic             core_valid;

    posit_decode u_decode_a (
        .clk       (clk),
        .operand   (in1),
        .value     (a_value),
        .magnitude (a_magnitude)
    );

    posit_decode u_decode_b (
        .clk       (clk),
        .operand   (in2),
        .value     (b_value),
        .magnitude (b_magnitude)
    );

    // start skips the decoders, the core counts their register in its valid chain
    posit_add_core u_add_core (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .a_value       (a_value),
        .a_magnitude   (a_magnitude),
        .b_value       (b_value),
        .b_magnitude   (b_magnitude),
        .sum_info      (sum_info),
        .norm_fraction (norm_fraction),
        .truncated     (truncated),
        .rounded_zero  (rounded_zero),
        .core_valid    (core_valid)
    );

    posit_round_pack u_round_pack (
        .clk           (clk),
        .reset         (reset),
        .sum_info      (sum_info),
        .norm_fraction (norm_fraction),
        .truncated     (truncated),
        .rounded_zero  (rounded_zero),
        .core_valid    (core_valid),
        .result        (result),
        .nar           (nar),
        .zero          (zero),
        .done          (done)
    );

endmodule

// ==== source/posit_decode.sv ====
/* Single register stage, outputs are combinational from the operand register
   NaR decodes with a zero magnitude, so only the nar flag identifies it */
`timescale 1ns/100ps

module posit_decode
    import posit_format_pkg::*, posit_value_pkg::*;
(
    input  logic             clk,
    input  logic [NBITS-1:0] operand,
    output posit_value       value,
    output logic [NBITS-2:0] magnitude
);

    logic [NBITS-1:0] operand_q;
    logic [NBITS-1:0] abs_word;
    logic [NBITS-2:0] body;          // Regime, exponent and fraction of the absolute word
    logic [NBITS-2:0] run_flip;
    logic [NBITS-2:0] body_shifted;
    logic             regime_bit;
    logic [RBITS-1:0] run_length;
    logic [RBITS-1:0] regime;
    logic [ES-1:0]    exponent;

    always_ff @(posedge clk)
    begin
        operand_q <= operand;
    end

    // Negative posits decode from their two's complement
    assign abs_word   = operand_q[NBITS-1] ? -operand_q : operand_q;
    assign body       = abs_word[NBITS-2:0];
    assign regime_bit = body[NBITS-2];

    // Turn the regime run into leading zeros, then find the first one
    assign run_flip = regime_bit ? ~body : body;

    always_comb
    begin
        run_length = RBITS'(NBITS - 1);   // Run fills the whole body
        for (int i = 0; i < NBITS - 1; i++)
        begin
            if (run_flip[i])
            begin
                run_length = RBITS'(NBITS - 2 - i);
            end
        end
    end

    // Run of ones gives k-1, run of zeros gives -k
    assign regime = regime_bit ? run_length - 1'b1 : -run_length;

    // Drop the run and its terminator, exponent lands at the top
    assign body_shifted = body << (run_length + 1'b1);
    assign exponent     = body_shifted[NBITS-2 -: ES];

    assign value.sign     = operand_q[NBITS-1];
    assign value.zero     = (operand_q == '0);
    assign value.nar      = (operand_q == NAR_WORD);
    assign value.scale    = {regime, exponent};                // regime * 8 + exponent
    assign value.fraction = body_shifted[NBITS-2-ES -: FBITS];

    assign magnitude = body;   // Orders posits by absolute value

endmodule

// ==== source/posit_format_pkg.sv ====
/* Fixed posit<32,3> format and the internal datapath widths
   No other word width or es value is supported */
package posit_format_pkg;

    localparam int NBITS = 32;                 // Posit word
    localparam int ES = 3;                     // Exponent field bits
    localparam int FBITS = NBITS - ES - 2;     // Widest fraction, left-justified
    localparam int ABITS = FBITS + 4;          // Hidden bit, fraction and three guard bits
    localparam int SBITS = 9;                  // Signed scale, regime * 8 + exponent
    localparam int RBITS = SBITS - ES;         // Signed regime value

    // Leading-zero counts over the ABITS+1 sum, also regime run lengths up to NBITS
    localparam int LZBITS = $clog2(ABITS + 2);

    // Regime run, terminator, exponent and fraction before the regime shift
    localparam int PBITS = NBITS + 1 + ES + ABITS;

    localparam int LATENCY = 8;                // Edges from start to done

    // Not-a-Real pattern, also the most negative two's complement word
    localparam logic [NBITS-1:0] NAR_WORD = {1'b1, {(NBITS - 1){1'b0}}};

endpackage

// ==== source/posit_round_pack.sv ====
/* Four register stages: pack, regime shift, round, output
   Rounds to nearest, ties to even, nonzero sums saturate at minpos or maxpos
   Outputs hold until the next clock edge, done marks the valid cycle */
`timescale 1ns/100ps

module posit_round_pack
    import posit_format_pkg::*, posit_value_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  posit_sum         sum_info,
    input  logic [ABITS:0]   norm_fraction,
    input  logic             truncated,
    input  logic             rounded_zero,
    input  logic             core_valid,
    output logic [NBITS-1:0] result,
    output logic             nar,
    output logic             zero,
    output logic             done
);

    logic signed [SBITS-1:0] scale;
    logic signed [SBITS-1:0] regime;
    logic                    regime_fill;   // 1 for a run of ones
    logic [LZBITS-1:0]       regime_len;
    logic [PBITS-1:0]        packed_field;

    logic              pack_valid;
    posit_sum          pack_info;
    logic [PBITS-1:0]  pack_field;
    logic [LZBITS-1:0] pack_shift;
    logic              pack_truncated;
    logic              pack_rounded_zero;

    logic [PBITS-1:0] shifted_field;
    logic             shift_valid;
    posit_sum         shift_info;
    logic [NBITS-2:0] shift_body;
    logic             shift_round_bit;
    logic             shift_sticky;
    logic             shift_rounded_zero;

    logic             round_up;
    logic [NBITS-2:0] body_rounded;
    logic             round_valid;
    posit_sum         round_info;
    logic [NBITS-2:0] round_body;
    logic             round_rounded_zero;

    logic [NBITS-1:0] unsigned_word;
    logic [NBITS-1:0] signed_word;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pack_valid  <= 1'b0;
            shift_valid <= 1'b0;
            round_valid <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            pack_valid  <= core_valid;
            shift_valid <= pack_valid;
            round_valid <= shift_valid;
            done        <= round_valid;
        end
    end

    assign scale       = sum_info.scale;
    assign regime      = scale >>> ES;
    assign regime_fill = ~scale[SBITS-1];
    assign regime_len  = scale[SBITS-1] ? LZBITS'(-regime) : LZBITS'(regime + 1);

    // Full-length run, trimmed to regime_len by the shift below
    assign packed_field = {{NBITS{regime_fill}}, ~regime_fill, scale[ES-1:0],
                           norm_fraction[ABITS-1:0]};

    always_ff @(posedge clk)
    begin
        pack_info         <= sum_info;
        pack_field        <= packed_field;
        pack_shift        <= LZBITS'(NBITS) - regime_len;
        pack_truncated    <= truncated;
        pack_rounded_zero <= rounded_zero;
    end

    assign shifted_field = pack_field << pack_shift;

    always_ff @(posedge clk)
    begin
        shift_info         <= pack_info;
        shift_body         <= shifted_field[PBITS-1 -: NBITS-1];
        shift_round_bit    <= shifted_field[PBITS-NBITS];
        shift_sticky       <= (|shifted_field[PBITS-NBITS-1:0]) | pack_truncated;
        shift_rounded_zero <= pack_rounded_zero;
    end

    // Ties go to the even word
    assign round_up = shift_round_bit & (shift_sticky | shift_body[0]);

    always_comb
    begin
        if (&shift_body)
            body_rounded = shift_body;   // Stays at maxpos, NaR is never reached
        else
            body_rounded = shift_body + round_up;
        if (body_rounded == '0)
            body_rounded = {{(NBITS - 2){1'b0}}, 1'b1};   // Underflow holds minpos
    end

    always_ff @(posedge clk)
    begin
        round_info         <= shift_info;
        round_body         <= body_rounded;
        round_rounded_zero <= shift_rounded_zero;
    end

    assign unsigned_word = {1'b0, round_body};
    assign signed_word   = round_info.sign ? -unsigned_word : unsigned_word;

    always_ff @(posedge clk)
    begin
        if (round_info.nar)
            result <= NAR_WORD;
        else if (round_info.zero | round_rounded_zero)
            result <= '0;
        else
            result <= signed_word;
        nar  <= round_info.nar;
        zero <= ~round_info.nar & (round_info.zero | round_rounded_zero);
    end

endmodule

// ==== source/posit_value_pkg.sv ====
/* Decoded posit operand and unrounded sum state
   fraction excludes the hidden bit, which is implied unless zero is set */
package posit_value_pkg;

    import posit_format_pkg::*;

    // One operand after decoding
    typedef struct packed {
        logic                    sign;
        logic                    zero;
        logic                    nar;
        logic signed [SBITS-1:0] scale;      // Regime * 2^ES + exponent
        logic [FBITS-1:0]        fraction;   // Left-justified
    } posit_value;

    // Result state travelling beside the normalized fraction
    typedef struct packed {
        logic                    sign;
        logic                    zero;       // Both operands were zero
        logic                    nar;        // Either operand was NaR
        logic signed [SBITS-1:0] scale;
    } posit_sum;

endpackage

// ==== test/tb_posit_ref.svh ====
/* Real-valued posit<32,3> reference, included inside the testbench module
   Exact for sums that fit a double, NaR is handled by the caller */
`ifndef TB_POSIT_REF_SVH
`define TB_POSIT_REF_SVH

localparam logic [NBITS-1:0] MAXPOS_WORD = {1'b0, {(NBITS - 1){1'b1}}};
localparam logic [NBITS-1:0] MINPOS_WORD = {{(NBITS - 1){1'b0}}, 1'b1};
localparam int MAX_SCALE = (NBITS - 2) * (1 << ES);   // 240
localparam int REF_BITS = 96;                         // Regime, exponent and a long fraction

function automatic real pow2(input int power);
    real p = 1.0;
    for (int i = 0; i < power; i++)
        p = p * 2.0;
    for (int i = 0; i > power; i--)
        p = p / 2.0;
    return p;
endfunction

// Power of two at or below a positive value
function automatic int real_scale(input real mag);
    int s = 0;
    while (mag >= 2.0)
    begin
        mag = mag / 2.0;
        s++;
    end
    while (mag < 1.0)
    begin
        mag = mag * 2.0;
        s--;
    end
    return s;
endfunction

function automatic real posit_to_real(input logic [NBITS-1:0] word);
    logic [NBITS-1:0] abs_word;
    logic [NBITS-2:0] body;
    logic [NBITS-2:0] rest;
    logic             lead;
    int               run;
    int               k;
    real              frac;
    real              value;
    if (word == '0)
        return 0.0;
    abs_word = word[NBITS-1] ? -word : word;
    body     = abs_word[NBITS-2:0];
    lead     = body[NBITS-2];
    run      = 0;
    while (run < NBITS - 1 && body[NBITS-2-run] == lead)
        run++;
    k     = lead ? run - 1 : -run;
    rest  = body << (run + 1);                 // Missing exponent bits read as zero
    frac  = rest[NBITS-2-ES:0];
    value = (1.0 + frac / pow2(NBITS - 1 - ES))
          * pow2(k * (1 << ES) + int'(rest[NBITS-2 -: ES]));
    return word[NBITS-1] ? -value : value;
endfunction

function automatic logic [NBITS-1:0] real_to_posit(input real x);
    logic [REF_BITS-1:0] bits;
    logic [NBITS-2:0]    body;
    logic [NBITS-1:0]    word;
    logic                round_bit;
    logic                sticky;
    real                 mag;
    real                 frac;
    int                  scale;
    int                  k;
    int                  e;
    int                  pos;
    if (x == 0.0)
        return '0;
    mag   = (x < 0.0) ? -x : x;
    scale = real_scale(mag);
    if (scale >= MAX_SCALE)
        body = MAXPOS_WORD[NBITS-2:0];         // At or beyond maxpos
    else if (scale < -MAX_SCALE)
        body = MINPOS_WORD[NBITS-2:0];         // Below minpos but not zero
    else
    begin
        frac = mag / pow2(scale) - 1.0;
        k    = scale >>> ES;
        e    = scale - k * (1 << ES);
        bits = '0;
        pos  = REF_BITS - 1;
        for (int i = 0; i < ((k >= 0) ? k + 1 : -k); i++)
        begin
            bits[pos] = (k >= 0);              // Regime run
            pos--;
        end
        bits[pos] = (k < 0);                   // Terminator
        pos--;
        for (int i = ES - 1; i >= 0; i--)
        begin
            bits[pos] = e[i];
            pos--;
        end
        while (pos >= 0)
        begin
            frac = frac * 2.0;
            bits[pos] = (frac >= 1.0);
            if (frac >= 1.0)
                frac = frac - 1.0;
            pos--;
        end
        body      = bits[REF_BITS-1 -: NBITS-1];
        round_bit = bits[REF_BITS-NBITS];
        sticky    = (|bits[REF_BITS-NBITS-1:0]) || (frac != 0.0);
        // Nearest, ties to even, never past maxpos
        if (round_bit && (sticky || body[0]) && !(&body))
            body = body + 1'b1;
        if (body == '0)
            body = MINPOS_WORD[NBITS-2:0];
    end
    word = {1'b0, body};
    return (x < 0.0) ? -word : word;
endfunction

`endif

// ==== test/tb_posit_adder.sv ====
/* Testbench for the pipelined posit<32,3> adder
   Random pairs keep their scales within about 20 so the real reference stays exact */
`timescale 1ns/100ps

module tb_posit_adder
    import posit_format_pkg::*;
();

    `include "tb_posit_ref.svh"

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 8;
    localparam int FIXED_VECTORS = 12;
    localparam int RANDOM_PAIRS = 1000;
    localparam int WIDE_PAIRS = 50;
    localparam int TIMEOUT_CYCLES =
        (FIXED_VECTORS + RANDOM_PAIRS + WIDE_PAIRS + LATENCY) * 2 + 100;

    logic             clk;
    logic             reset;
    logic             start;
    logic [NBITS-1:0] in1;
    logic [NBITS-1:0] in2;
    logic [NBITS-1:0] result;
    logic             nar;
    logic             zero;
    logic             done;

    integer seed = 32'hcee5;
    int     cycle_count = 0;
    int     checks = 0;
    int     errors = 0;
    int     mark_checks = 0;
    int     mark_errors = 0;

    logic [NBITS-1:0] expect_q[$];   // One entry per start, in issue order
    string            name_q[$];
    int               issue_q[$];

    posit_adder u_posit_adder (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .in1    (in1),
        .in2    (in2),
        .result (result),
        .nar    (nar),
        .zero   (zero),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // Expected sum from the real value, NaR dominates
    function automatic logic [NBITS-1:0] expected_sum(input logic [NBITS-1:0] a,
                                                      input logic [NBITS-1:0] b);
        real sum;
        if (a == NAR_WORD || b == NAR_WORD)
            return NAR_WORD;
        sum = posit_to_real(a) + posit_to_real(b);
        return real_to_posit(sum);   // Zero sum maps to the zero word
    endfunction

    task automatic issue(input string name, input logic [NBITS-1:0] a,
                         input logic [NBITS-1:0] b, input logic [NBITS-1:0] expected);
        start = 1'b1;
        in1   = a;
        in2   = b;
        expect_q.push_back(expected);
        name_q.push_back(name);
        issue_q.push_back(cycle_count);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic make_operand(input int scale, output logic [NBITS-1:0] word);
        real value;
        value = (1.0 + ($random(seed) & 32'h7fffffff) / 2147483648.0) * pow2(scale);
        if ($random(seed) & 1)
            value = -value;   // Mixed signs
        word = real_to_posit(value);
    endtask

    task automatic finish_group(input string group);
        start = 1'b0;
        while (expect_q.size() != 0)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        $display("test %-10s %0d checks, %0d errors", group, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // Results are sampled on the falling edge, one queue entry per done
    initial
    begin
        logic [NBITS-1:0] expected;
        string            name;
        int               latency;
        forever
        begin
            @(negedge clk);
            if (done === 1'b1)
            begin
                if (expect_q.size() == 0)
                begin
                    errors++;
                    $display("done rose with no operation in flight");
                end
                else
                begin
                    expected = expect_q.pop_front();
                    name     = name_q.pop_front();
                    latency  = cycle_count - issue_q.pop_front();
                    checks++;
                    if (result !== expected)
                    begin
                        errors++;
                        $display("error %s result: expected %h, actual %h", name, expected,
                                 result);
                    end
                    if (nar !== (expected == NAR_WORD))
                    begin
                        errors++;
                        $display("error %s nar: expected %b, actual %b", name,
                                 expected == NAR_WORD, nar);
                    end
                    if (zero !== (expected == '0))
                    begin
                        errors++;
                        $display("error %s zero: expected %b, actual %b", name,
                                 expected == '0, zero);
                    end
                    if (latency != LATENCY)
                    begin
                        errors++;
                        $display("error %s latency: expected %0d, actual %0d", name, LATENCY,
                                 latency);
                    end
                end
            end
        end
    end

    initial
    begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: results still outstanding after %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        logic [NBITS-1:0] one;
        logic [NBITS-1:0] x;
        logic [NBITS-1:0] a;
        logic [NBITS-1:0] b;
        int               scale_a;
        int               scale_b;
        reset = 1'b1;
        start = 1'b0;
        in1   = '0;
        in2   = '0;

        // done must stay low through reset and the idle cycles after it
        for (int i = 0; i < RESET_CYCLES + 3; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i == RESET_CYCLES - 1)
                reset = 1'b0;
            checks++;
            if (done !== 1'b0)
            begin
                errors++;
                $display("done is not low before the first start (cycle %0d)", i);
            end
        end
        finish_group("reset");

        one = real_to_posit(1.0);
        x   = real_to_posit(3.25);
        issue("nar_plus_one", NAR_WORD, one, NAR_WORD);
        issue("x_plus_nar", x, NAR_WORD, NAR_WORD);
        issue("zero_plus_zero", '0, '0, '0);
        issue("x_minus_x", x, -x, '0);
        issue("zero_plus_x", '0, x, x);
        issue("neg_x_plus_zero", -x, '0, -x);
        finish_group("special");

        issue("one_plus_one", one, one, expected_sum(one, one));
        b = real_to_posit(-0.5);
        issue("one_minus_half", one, b, expected_sum(one, b));
        a = real_to_posit(3.0);
        b = real_to_posit(5.0);
        issue("three_plus_five", a, b, expected_sum(a, b));
        a = real_to_posit(-2.0);
        b = real_to_posit(-6.0);
        issue("neg_two_plus_neg_six", a, b, expected_sum(a, b));
        finish_group("directed");

        // Back-to-back issue, one pair per cycle
        for (int i = 0; i < RANDOM_PAIRS; i++)
        begin
            scale_a = $random(seed) % 61;
            scale_b = scale_a + $random(seed) % 21;
            make_operand(scale_a, a);
            make_operand(scale_b, b);
            issue($sformatf("random_%0d", i), a, b, expected_sum(a, b));
        end
        finish_group("random");

        // Smaller operand lies below the round bit of the larger one
        for (int i = 0; i < WIDE_PAIRS; i++)
        begin
            scale_a = $random(seed) % 41;
            scale_b = scale_a - (FBITS + 5) - ($random(seed) & 63);
            make_operand(scale_a, a);
            make_operand(scale_b, b);
            if ($random(seed) & 1)
                issue($sformatf("wide_%0d", i), b, a, a);
            else
                issue($sformatf("wide_%0d", i), a, b, a);
        end
        finish_group("wide");

        issue("maxpos_plus_maxpos", MAXPOS_WORD, MAXPOS_WORD, MAXPOS_WORD);
        issue("minpos_plus_minpos", MINPOS_WORD, MINPOS_WORD,
              expected_sum(MINPOS_WORD, MINPOS_WORD));
        finish_group("saturation");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
